//--- tb.f
verilog/game_pkg.sv
verilog/pixel_pkg.sv
verilog/move_input.sv
verilog/game_control.sv
verilog/snake_body.sv
verilog/apple_gen.sv
verilog/pixel_out.sv
verilog/snake_top.sv
tests/tb_snake.sv

//--- run.sh
#!/usr/bin/env bash
# build and run the snake testbench with Verilator
cd "$(dirname "$0")" \
	&& verilator --binary --timing --assert -Wno-fatal -f tb.f \
		--top-module tb_snake --Mdir obj_dir -o sim_snake \
	&& ./obj_dir/sim_snake \
	|| { echo "snake simulation failed"; exit 1; }

//--- tests/tb_snake.sv
`timescale 1ns/1ps

module tb_snake
	import game_pkg::*;
	import pixel_pkg::*;
();

	localparam int CLK_HALF = 5;
	localparam int RESET_CYCLES = 5;
	localparam int STEP_BUDGET = 3000;
	localparam int PHASE_LIMIT = 2000;
	localparam int QUIET_CYCLES = 40;
	localparam int NUM_ROWS = 21;

	// button patterns, fields are left, right, down, up
	localparam buttons_t B_NONE = 4'b0000;
	localparam buttons_t B_LEFT = 4'b1000;
	localparam buttons_t B_RIGHT = 4'b0100;
	localparam buttons_t B_DOWN = 4'b0010;
	localparam buttons_t B_UP = 4'b0001;

	// row kinds: start a game, or one step with its expected outcome
	localparam logic [1:0] K_START = 2'd0;
	localparam logic [1:0] K_MOVE = 2'd1;
	localparam logic [1:0] K_ATE = 2'd2;
	localparam logic [1:0] K_DIE = 2'd3;

	typedef struct packed {
		buttons_t btn;
		logic [13:0] word;
		logic [1:0] kind;
		logic [5:0] reps;
	} step_t;

	// rand_word is {y field, x field}
	step_t steps [NUM_ROWS] = '{
		// apple at (23,22), both fields folded from 120 and 121
		'{B_NONE, {7'd120, 7'd121}, K_START, 6'd1},
		'{B_NONE, 14'd0, K_MOVE, 6'd1},
		// reverse request while heading left
		'{B_RIGHT, 14'd0, K_MOVE, 6'd1},
		'{B_NONE, 14'd0, K_MOVE, 6'd4},
		// turn takes effect one step later
		'{B_DOWN, 14'd0, K_MOVE, 6'd1},
		'{B_NONE, 14'd0, K_MOVE, 6'd1},
		// four colour 7 apples down column 23, length 12, 19, 26, then capped
		'{B_NONE, {7'd21, 7'd21}, K_ATE, 6'd1},
		'{B_NONE, {7'd22, 7'd21}, K_ATE, 6'd1},
		'{B_NONE, {7'd23, 7'd21}, K_ATE, 6'd1},
		'{B_NONE, {7'd98, 7'd98}, K_ATE, 6'd1},
		// small loop back into the body
		'{B_LEFT, 14'd0, K_MOVE, 6'd1},
		'{B_DOWN, 14'd0, K_MOVE, 6'd1},
		'{B_RIGHT, 14'd0, K_MOVE, 6'd1},
		'{B_UP, 14'd0, K_MOVE, 6'd1},
		'{B_NONE, 14'd0, K_DIE, 6'd1},
		// restart, then run up into the top wall
		'{B_NONE, {7'd98, 7'd98}, K_START, 6'd1},
		'{B_UP, 14'd0, K_MOVE, 6'd1},
		'{B_NONE, 14'd0, K_MOVE, 6'd18},
		'{B_NONE, 14'd0, K_DIE, 6'd1},
		// fold of exactly 100 puts the apple x on the low wall line
		'{B_NONE, {7'd5, 7'd100}, K_START, 6'd1},
		'{B_NONE, 14'd0, K_MOVE, 6'd3}
	};

	logic clk = 1'b0;
	logic rst_n;
	buttons_t buttons;
	logic step_tick;
	logic [13:0] rand_word;
	logic credit_return = 1'b0;
	pixel_t pixel;
	logic pixel_valid;
	logic game_over;
	len_t snake_len;

	// model state
	point_t mseg [MAX_LEN];
	len_t mlen;
	point_t mapple;
	colour_t mcol;
	dir_t mcom;
	dir_t mpend;

	// credit sink state
	pixel_t rx_q [$];
	int held = 0;
	int owed = 0;
	int gap = 0;
	int unsigned lcg_state = 32'd87347;

	snake_top snake_top_i (
		.clk(clk),
		.rst_n(rst_n),
		.buttons(buttons),
		.step_tick(step_tick),
		.rand_word(rand_word),
		.credit_return(credit_return),
		.pixel(pixel),
		.pixel_valid(pixel_valid),
		.game_over(game_over),
		.snake_len(snake_len)
	);

	always #CLK_HALF clk = ~clk;

	task automatic fail_run(input string why);
		$display("%s", why);
		$display("Simulation finished: FAIL");
		$fatal(1);
	endtask

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		if (got !== exp)
			fail_run($sformatf("ERROR %s: got 0x%0h expected 0x%0h", name, got, exp));
	endtask

	function automatic int unsigned lcg_next(input int unsigned s);
		return s * 32'd1103515245 + 32'd12345;
	endfunction

	// random field into 0..99, then two clear of the wall
	function automatic coord_x_t fold_field(input logic [6:0] f);
		int v;
		v = int'(f);
		if (v >= 100)
			v = v - 100;
		return coord_x_t'(v + 2);
	endfunction

	// first allowed button by priority, else keep the current request
	function automatic dir_t pick_dir(input buttons_t b, input dir_t base, input dir_t cur);
		if (b.left && base != RIGHT)
			return LEFT;
		if (b.right && base != LEFT)
			return RIGHT;
		if (b.down && base != UP)
			return DOWN;
		if (b.up && base != DOWN)
			return UP;
		return cur;
	endfunction

	task automatic model_load();
		for (int i = 0; i < 32; i++)
		begin
			mseg[i].x = (i < 5) ? coord_x_t'(30 + i) : '0;
			mseg[i].y = (i < 5) ? 7'd20 : '0;
		end
		mlen = 6'd5;
		mcom = LEFT;
		mpend = LEFT;
	endtask

	task automatic model_apple(input logic [13:0] word);
		mapple.x = fold_field(word[6:0]);
		mapple.y = coord_y_t'(fold_field(word[13:7]));
		mcol = (mapple.x[2:0] == 3'b000) ? 3'b100 : mapple.x[2:0];
	endtask

	task automatic model_grow();
		int sum;
		sum = int'(mlen) + int'(mcol);
		if (sum > 32)
			sum = 32;
		mlen = len_t'(sum);
	endtask

	// head follows the direction committed at the previous step
	task automatic model_step(input buttons_t b, output logic [1:0] kind);
		point_t nh;
		logic hit;
		mpend = pick_dir(b, mcom, mpend);
		nh = mseg[0];
		case (mcom)
			LEFT: nh.x = nh.x - 8'd1;
			RIGHT: nh.x = nh.x + 8'd1;
			DOWN: nh.y = nh.y + 7'd1;
			default: nh.y = nh.y - 7'd1;
		endcase
		for (int i = 31; i > 0; i--)
			mseg[i] = mseg[i - 1];
		mseg[0] = nh;
		mcom = mpend;
		mpend = pick_dir(b, mcom, mpend);
		hit = nh.x < 8'd2 || nh.x > 8'd119 || nh.y < 7'd2 || nh.y > 7'd117;
		for (int i = 1; i < int'(mlen); i++)
			if (mseg[i] == nh)
				hit = 1'b1;
		if (hit)
			kind = K_DIE;
		else if (nh == mapple)
			kind = K_ATE;
		else
			kind = K_MOVE;
	endtask

	// credit sink, frees one buffered pixel after a random gap
	always @(posedge clk)
	begin
		if (!rst_n)
		begin
			held = 0;
			owed = 0;
			gap = 0;
			credit_return <= 1'b0;
		end
		else
		begin
			if (pixel_valid)
			begin
				if (held >= int'(CREDIT_MAX))
					fail_run("pixel arrived while the sink had no free buffer entry");
				rx_q.push_back(pixel);
				owed = owed + 1;
			end
			held = held + int'(pixel_valid) - int'(credit_return);
			credit_return <= 1'b0;
			if (gap != 0)
				gap = gap - 1;
			else if (owed != 0)
			begin
				credit_return <= 1'b1;
				owed = owed - 1;
				lcg_state = lcg_next(lcg_state);
				gap = int'((lcg_state >> 16) % 4);
			end
		end
	end

	// apple first, then the body from head to tail
	task automatic expect_frame();
		int waited;
		pixel_t got;
		waited = 0;
		while (rx_q.size() < int'(mlen) + 1)
		begin
			@(negedge clk);
			waited++;
			if (waited > PHASE_LIMIT)
				fail_run("frame did not complete within the phase limit");
		end
		for (int i = 0; i <= int'(mlen); i++)
		begin
			got = rx_q.pop_front();
			check_value("pixel.x", got.pt.x, (i == 0) ? mapple.x : mseg[i - 1].x);
			check_value("pixel.y", got.pt.y, (i == 0) ? mapple.y : mseg[i - 1].y);
			check_value("pixel.colour", got.colour, (i == 0) ? mcol : SNAKE_COLOUR);
		end
		check_value("game_over", game_over, 1'b0);
		check_value("snake_len", snake_len, mlen);
	endtask

	task automatic start_game(input logic [13:0] word);
		@(posedge clk);
		rand_word <= word;
		buttons <= B_UP;
		repeat (3) @(posedge clk);
		buttons <= B_NONE;
		model_load();
		model_apple(word);
		expect_frame();
	endtask

	task automatic run_step(input step_t row);
		logic [1:0] kind;
		int waited;
		@(posedge clk);
		buttons <= row.btn;
		rand_word <= row.word;
		repeat (2) @(posedge clk);
		step_tick <= 1'b1;
		@(posedge clk);
		step_tick <= 1'b0;
		model_step(row.btn, kind);
		check_value("outcome", kind, row.kind);
		if (kind == K_DIE)
		begin
			waited = 0;
			while (game_over !== 1'b1)
			begin
				@(negedge clk);
				waited++;
				if (waited > PHASE_LIMIT)
					fail_run("game_over did not rise after a collision");
			end
			// dead game sends nothing
			repeat (QUIET_CYCLES) @(negedge clk);
			check_value("pixels after death", rx_q.size(), 0);
			check_value("snake_len", snake_len, mlen);
		end
		else
		begin
			if (kind == K_ATE)
			begin
				model_grow();
				model_apple(row.word);
			end
			expect_frame();
		end
	endtask

	// budget scales with the number of steps in the table
	initial
	begin
		int total;
		total = 0;
		for (int r = 0; r < NUM_ROWS; r++)
			total += (steps[r].kind == K_START) ? 1 : int'(steps[r].reps);
		repeat (total * STEP_BUDGET + RESET_CYCLES) @(posedge clk);
		fail_run("watchdog expired before the step table finished");
	end

	initial
	begin
		rst_n = 1'b0;
		buttons = B_NONE;
		step_tick = 1'b0;
		rand_word = '0;
		repeat (RESET_CYCLES) @(posedge clk);
		rst_n <= 1'b1;
		@(negedge clk);
		check_value("pixel_valid", pixel_valid, 1'b0);
		check_value("game_over", game_over, 1'b0);
		check_value("snake_len", snake_len, 6'd5);
		for (int r = 0; r < NUM_ROWS; r++)
		begin
			if (steps[r].kind == K_START)
				start_game(steps[r].word);
			else
				repeat (steps[r].reps) run_step(steps[r]);
		end
		// no stray pixel may trail the last frame
		repeat (QUIET_CYCLES) @(negedge clk);
		check_value("pixels after last frame", rx_q.size(), 0);
		$display("Simulation finished: PASS");
		$finish;
	end

endmodule

//--- verilog/snake_top.sv
`timescale 1ns/1ps

module snake_top
	import game_pkg::*;
	import pixel_pkg::*;
(
	input logic clk,
	input logic rst_n,
	input buttons_t buttons,
	input logic step_tick,
	input logic [13:0] rand_word,
	input logic credit_return,
	output pixel_t pixel,
	output logic pixel_valid,
	output logic game_over,
	output len_t snake_len
);

	// control strobes and their done pulses
	logic load;
	logic make_apple;
	logic step;
	logic check_start;
	logic check_done;
	logic hit;
	logic ate;
	logic grow;
	logic frame_start;
	logic frame_done;

	// game state shared between the blocks
	dir_t dir;
	point_t apple;
	colour_t apple_colour;
	len_t rd_index;
	point_t rd_point;

	// steering from the buttons
	move_input move_input_i (
		.clk(clk),
		.rst_n(rst_n),
		.buttons(buttons),
		.load(load),
		.step(step),
		.dir(dir)
	);

	game_control game_control_i (
		.clk(clk),
		.rst_n(rst_n),
		.buttons(buttons),
		.step_tick(step_tick),
		.check_done(check_done),
		.hit(hit),
		.ate(ate),
		.frame_done(frame_done),
		.load(load),
		.make_apple(make_apple),
		.step(step),
		.check_start(check_start),
		.grow(grow),
		.frame_start(frame_start),
		.game_over(game_over)
	);

	// body length goes straight out as the score view
	snake_body snake_body_i (
		.clk(clk),
		.rst_n(rst_n),
		.load(load),
		.step(step),
		.check_start(check_start),
		.grow(grow),
		.dir(dir),
		.apple(apple),
		.apple_colour(apple_colour),
		.rd_index(rd_index),
		.rd_point(rd_point),
		.len(snake_len),
		.check_done(check_done),
		.hit(hit),
		.ate(ate)
	);

	apple_gen apple_gen_i (
		.clk(clk),
		.rst_n(rst_n),
		.make_apple(make_apple),
		.rand_word(rand_word),
		.apple(apple),
		.apple_colour(apple_colour)
	);

	pixel_out pixel_out_i (
		.clk(clk),
		.rst_n(rst_n),
		.frame_start(frame_start),
		.credit_return(credit_return),
		.apple(apple),
		.apple_colour(apple_colour),
		.len(snake_len),
		.rd_point(rd_point),
		.rd_index(rd_index),
		.pixel(pixel),
		.pixel_valid(pixel_valid),
		.frame_done(frame_done)
	);

endmodule

//--- verilog/pixel_out.sv
`timescale 1ns/1ps

module pixel_out
	import game_pkg::*;
	import pixel_pkg::*;
(
	input logic clk,
	input logic rst_n,
	input logic frame_start,
	input logic credit_return,
	input point_t apple,
	input colour_t apple_colour,
	input len_t len,
	input point_t rd_point,
	output len_t rd_index,
	output pixel_t pixel,
	output logic pixel_valid,
	output logic frame_done
);

	// slot 0 is the apple, slot k is body entry k-1
	logic busy;
	len_t slot;
	credit_t credits;
	logic last;

	// nothing goes out without a free entry at the receiver
	assign pixel_valid = busy && credits != '0;
	assign last = slot == len;
	// wraps at slot 0, where the read is not used
	assign rd_index = slot - len_t'(1);

	always_comb
	begin
		if (slot == '0)
		begin
			pixel.pt = apple;
			pixel.colour = apple_colour;
		end
		else
		begin
			pixel.pt = rd_point;
			pixel.colour = SNAKE_COLOUR;
		end
	end

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			busy <= 1'b0;
			slot <= '0;
			frame_done <= 1'b0;
			credits <= CREDIT_MAX;
		end
		else
		begin
			frame_done <= 1'b0;
			if (frame_start)
			begin
				busy <= 1'b1;
				slot <= '0;
			end
			else if (pixel_valid)
			begin
				// done pulses the cycle after the last pixel
				if (last)
				begin
					busy <= 1'b0;
					frame_done <= 1'b1;
				end
				else
					slot <= slot + len_t'(1);
			end
			// send and return in one cycle cancel out
			case ({pixel_valid, credit_return})
				2'b10: credits <= credits - credit_t'(1);
				2'b01: credits <= credits + credit_t'(1);
				default: credits <= credits;
			endcase
		end
	end

	// receiver returned more than it was sent
	a_credit_max: assert property (
		@(posedge clk) disable iff (!rst_n) credits <= CREDIT_MAX
	);

	// a new frame only starts once the previous one has fully gone out
	a_no_start_while_busy: assert property (
		@(posedge clk) disable iff (!rst_n) frame_start |-> !busy
	);

endmodule

//--- verilog/apple_gen.sv
`timescale 1ns/1ps

module apple_gen
	import game_pkg::*;
	import pixel_pkg::*;
(
	input logic clk,
	input logic rst_n,
	input logic make_apple,
	input logic [13:0] rand_word,
	output point_t apple,
	output colour_t apple_colour
);

	coord_x_t new_x;
	coord_x_t new_y;
	colour_t new_colour;

	// fold a 7-bit field into 0..99, then step clear of the low wall
	function automatic coord_x_t fold(input logic [6:0] field);
		logic [6:0] base;
		base = (field >= APPLE_FOLD) ? field - APPLE_FOLD : field;
		return coord_x_t'(base) + APPLE_OFS;
	endfunction

	assign new_x = fold(rand_word[6:0]);
	assign new_y = fold(rand_word[13:7]);
	// colour follows the x just produced, black is replaced by red
	assign new_colour = (new_x[2:0] == 3'b000) ? APPLE_RED : new_x[2:0];

	always_ff @(posedge clk)
	begin
		if (make_apple)
		begin
			apple.x <= new_x;
			apple.y <= coord_y_t'(new_y);
			apple_colour <= new_colour;
		end
	end

	// every new apple lands on the board with a visible colour
	a_apple_on_board: assert property (
		@(posedge clk) disable iff (!rst_n)
		make_apple |=> apple.x < BOARD_W && apple.y < BOARD_H && apple_colour != '0
	);

endmodule

//--- verilog/snake_body.sv
`timescale 1ns/1ps

module snake_body
	import game_pkg::*;
	import pixel_pkg::*;
(
	input logic clk,
	input logic rst_n,
	input logic load,
	input logic step,
	input logic check_start,
	input logic grow,
	input dir_t dir,
	input point_t apple,
	input colour_t apple_colour,
	input len_t rd_index,
	output point_t rd_point,
	output len_t len,
	output logic check_done,
	output logic hit,
	output logic ate
);

	// entry 0 is the head, higher entries trail toward the tail
	point_t seg [MAX_LEN];
	len_t len_q;
	point_t head;
	point_t next_head;
	len_t scan_idx;
	logic scanning;
	logic hit_acc;
	logic wall;
	logic self_hit;
	logic [6:0] grown;

	assign head = seg[0];

	// left and up count down, right and down count up
	always_comb
	begin
		next_head = head;
		case (dir)
			LEFT: next_head.x = head.x - 8'd1;
			RIGHT: next_head.x = head.x + 8'd1;
			DOWN: next_head.y = head.y + 7'd1;
			default: next_head.y = head.y - 7'd1;
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (load)
		begin
			// horizontal start body, head at the left end
			for (int i = 0; i < MAX_LEN; i++)
			begin
				if (i < START_LEN)
				begin
					seg[i].x <= START_X + coord_x_t'(i);
					seg[i].y <= START_Y;
				end
				else
					seg[i] <= '0;
			end
		end
		else if (step)
		begin
			seg[0] <= next_head;
			for (int i = 1; i < MAX_LEN; i++)
				seg[i] <= seg[i - 1];
		end
	end

	// wrap below zero lands far above the high walls
	assign wall = head.x < WALL_LO || head.x > WALL_X_HI
		|| head.y < WALL_LO || head.y > WALL_Y_HI;
	assign self_hit = seg[scan_idx[4:0]] == head;

	// scan one body entry per cycle, then the walls in the final cycle
	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			scanning <= 1'b0;
			scan_idx <= '0;
			hit_acc <= 1'b0;
			check_done <= 1'b0;
			hit <= 1'b0;
			ate <= 1'b0;
		end
		else
		begin
			check_done <= 1'b0;
			if (check_start)
			begin
				scanning <= 1'b1;
				scan_idx <= len_t'(1);
				hit_acc <= 1'b0;
			end
			else if (scanning)
			begin
				if (scan_idx < len_q)
				begin
					hit_acc <= hit_acc | self_hit;
					scan_idx <= scan_idx + len_t'(1);
				end
				else
				begin
					scanning <= 1'b0;
					check_done <= 1'b1;
					hit <= hit_acc | wall;
					ate <= head == apple;
				end
			end
		end
	end

	// growth by apple colour, capped at the stored body size
	assign grown = {1'b0, len_q} + 7'(apple_colour);

	always_ff @(posedge clk)
	begin
		if (!rst_n || load)
			len_q <= START_LEN;
		else if (grow)
			len_q <= (grown > 7'(MAX_LEN)) ? MAX_LEN : grown[5:0];
	end

	// read port for the pixel sequencer
	assign rd_point = seg[rd_index[4:0]];
	assign len = len_q;

	a_len_range: assert property (
		@(posedge clk) disable iff (!rst_n) len_q >= START_LEN && len_q <= MAX_LEN
	);

endmodule

//--- verilog/game_control.sv
`timescale 1ns/1ps

module game_control
	import game_pkg::*;
(
	input logic clk,
	input logic rst_n,
	input buttons_t buttons,
	input logic step_tick,
	input logic check_done,
	input logic hit,
	input logic ate,
	input logic frame_done,
	output logic load,
	output logic make_apple,
	output logic step,
	output logic check_start,
	output logic grow,
	output logic frame_start,
	output logic game_over
);

	typedef enum logic [3:0] {
		S_MENU,
		S_RELEASE,
		S_LOAD,
		S_APPLE,
		S_DRAW,
		S_DRAWING,
		S_WAIT_TICK,
		S_MOVE,
		S_CHECK,
		S_CHECKING,
		S_MUNCH,
		S_DEAD
	} state_t;

	state_t state;
	state_t next_state;
	logic any_button;
	logic game_over_q;

	assign any_button = |buttons;

	always_comb
	begin
		next_state = state;
		case (state)
			// press then release starts a game, from menu or after death
			S_MENU: if (any_button) next_state = S_RELEASE;
			S_RELEASE: if (!any_button) next_state = S_LOAD;
			S_LOAD: next_state = S_APPLE;
			S_APPLE: next_state = S_DRAW;
			// one strobe cycle, then wait for the last pixel
			S_DRAW: next_state = S_DRAWING;
			S_DRAWING: if (frame_done) next_state = S_WAIT_TICK;
			// ticks outside this state are simply not looked at
			S_WAIT_TICK: if (step_tick) next_state = S_MOVE;
			S_MOVE: next_state = S_CHECK;
			S_CHECK: next_state = S_CHECKING;
			S_CHECKING:
			begin
				if (check_done)
				begin
					// a hit wins over an apple on the same square
					if (hit)
						next_state = S_DEAD;
					else if (ate)
						next_state = S_MUNCH;
					else
						next_state = S_DRAW;
				end
			end
			// grow first, the new apple follows in the apple state
			S_MUNCH: next_state = S_APPLE;
			S_DEAD: if (any_button) next_state = S_RELEASE;
			default: next_state = S_MENU;
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			state <= S_MENU;
			game_over_q <= 1'b0;
		end
		else
		begin
			state <= next_state;
			// held through dead and the restart release, dropped on load
			if (state == S_CHECKING && check_done && hit)
				game_over_q <= 1'b1;
			else if (state == S_LOAD)
				game_over_q <= 1'b0;
		end
	end

	// each strobe is a single cycle state
	assign load = state == S_LOAD;
	assign make_apple = state == S_APPLE;
	assign frame_start = state == S_DRAW;
	assign step = state == S_MOVE;
	assign check_start = state == S_CHECK;
	assign grow = state == S_MUNCH;
	assign game_over = game_over_q;

	// no frame may be started while the game is over
	a_no_frame_when_dead: assert property (
		@(posedge clk) disable iff (!rst_n) game_over |-> !frame_start
	);

endmodule

//--- verilog/move_input.sv
`timescale 1ns/1ps

module move_input
	import game_pkg::*;
(
	input logic clk,
	input logic rst_n,
	input buttons_t buttons,
	input logic load,
	input logic step,
	output dir_t dir
);

	// pending is the latest legal request, committed is what the head follows
	dir_t pending;
	dir_t committed;
	dir_t base;
	dir_t request;

	// on a step edge the pending value becomes the committed one,
	// so a new request must be judged against it
	assign base = step ? pending : committed;

	// priority left, right, down, up
	// a refused button lets the next one through
	always_comb
	begin
		request = pending;
		if (buttons.left && base != RIGHT)
			request = LEFT;
		else if (buttons.right && base != LEFT)
			request = RIGHT;
		else if (buttons.down && base != UP)
			request = DOWN;
		else if (buttons.up && base != DOWN)
			request = UP;
	end

	always_ff @(posedge clk)
	begin
		if (!rst_n || load)
		begin
			// a new game always starts heading left
			pending <= LEFT;
			committed <= LEFT;
		end
		else
		begin
			pending <= request;
			if (step)
				committed <= pending;
		end
	end

	assign dir = committed;

endmodule

//--- verilog/pixel_pkg.sv
package pixel_pkg;

	// 3-bit rgb, one bit per channel
	typedef logic [2:0] colour_t;

	localparam colour_t SNAKE_COLOUR = 3'b010;
	// an apple whose x gives colour bits of zero is drawn red
	localparam colour_t APPLE_RED = 3'b100;

	// one plotted pixel on the stream
	typedef struct packed {
		game_pkg::point_t pt;
		colour_t colour;
	} pixel_t;

	// receiver buffer depth, also the credit count after reset
	typedef logic [2:0] credit_t;

	localparam credit_t CREDIT_MAX = 3'd4;

endpackage

//--- verilog/game_pkg.sv
package game_pkg;

	// board and wall limits, walls only act as a collision rule
	localparam int unsigned BOARD_W = 160;
	localparam int unsigned BOARD_H = 120;
	localparam int unsigned WALL_LO = 2;

	typedef logic [7:0] coord_x_t;
	typedef logic [6:0] coord_y_t;
	// length needs one extra bit so that a full body of 32 fits
	typedef logic [5:0] len_t;

	localparam coord_x_t WALL_X_HI = 8'd119;
	localparam coord_y_t WALL_Y_HI = 7'd117;

	// body storage and the snake loaded at game start
	localparam len_t MAX_LEN = 6'd32;
	localparam len_t START_LEN = 6'd5;
	localparam coord_x_t START_X = 8'd30;
	localparam coord_y_t START_Y = 7'd20;

	// random field fold for apple placement
	localparam logic [6:0] APPLE_FOLD = 7'd100;
	localparam coord_x_t APPLE_OFS = 8'd2;

	typedef struct packed {
		coord_x_t x;
		coord_y_t y;
	} point_t;

	typedef enum logic [1:0] {
		LEFT = 2'b00,
		RIGHT = 2'b01,
		DOWN = 2'b10,
		UP = 2'b11
	} dir_t;

	typedef struct packed {
		logic left;
		logic right;
		logic down;
		logic up;
	} buttons_t;

endpackage
